// ==== hdl/cpu_cfg.svh ====
// processor configuration

`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data path and bus width
`define WORD_W 32

// memory address width, PC and MAR carry this many bits
`define ADDR_W 9

// general register count, matches the 4-bit register fields
`define NUM_REGS 16

// index of the final control step, T5
`define LAST_STEP 5

`endif

// ==== hdl/cpuPkg.sv ====
// processor types

`default_nettype none

package cpuPkg;

	// instruction opcode field, bits 31..27, unlisted codes run as no-op
	typedef enum logic [4:0] {
		opLdi  = 5'h01,
		opAdd  = 5'h02,
		opSub  = 5'h03,
		opAnd  = 5'h04,
		opOr   = 5'h05,
		opShl  = 5'h06,
		opShr  = 5'h07,
		opNot  = 5'h08,
		opIn   = 5'h09,
		opOut  = 5'h0A,
		opHalt = 5'h1F
	} opcodeT;

	typedef enum logic [2:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluShl, aluShr, aluNot
	} aluOpT;

	// one bus driver per step
	typedef enum logic [2:0] {
		srcNone, srcPc, srcMdr, srcReg, srcZ, srcImm, srcInPort
	} busSrcT;

	typedef enum logic [1:0] {
		selRa, selRb, selRc
	} regSelT;

endpackage

`default_nettype wire

// ==== hdl/ctrlIf.sv ====
// control strobe bundle

`timescale 1ns/10ps
`default_nettype none

interface ctrlIf;
	import cpuPkg::*;

	busSrcT busSrc; // bus driver this step
	regSelT regSel; // IR field naming the register
	logic regIn;
	logic marIn;
	logic mdrIn;
	logic irIn;
	logic yIn;
	logic zIn;
	logic incPc;
	logic pcClear; // restart at address 0
	logic read; // memory read, MDR takes memData
	logic outIn;
	aluOpT aluOp;

	modport ctl (
		output busSrc, regSel, regIn, marIn, mdrIn, irIn, yIn, zIn,
		output incPc, pcClear, read, outIn, aluOp
	);

	modport dp (
		input busSrc, regSel, regIn, marIn, mdrIn, irIn, yIn, zIn,
		input incPc, pcClear, read, outIn, aluOp
	);

endinterface

`default_nettype wire

// ==== hdl/stepCounter.sv ====
// control step timer

`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module stepCounter (
	input logic Clock,
	input logic rstN,
	input logic advance,
	input logic clear,
	output logic [2:0] step
);

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			step <= '0;
		end else if (clear) begin
			step <= '0; // end of instruction, back to T0
		end else if (advance) begin
			step <= step + 3'd1;
		end
	end

	// the decoder must end every instruction by T5
	assert property (@(posedge Clock) disable iff (!rstN)
		step <= 3'(`LAST_STEP))
		else $error("control step beyond T%0d", `LAST_STEP);

endmodule

`default_nettype wire

// ==== hdl/controlFsm.sv ====
// control unit

`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module controlFsm (
	input logic Clock,
	input logic rstN,
	input logic start,
	input logic [`WORD_W-1:0] ir,
	input logic [2:0] step,
	output logic stepAdvance,
	output logic stepClear,
	output logic running,
	output logic halted,
	ctrlIf.ctl ctl
);
	import cpuPkg::*;

	typedef enum logic [1:0] {stIdle, stRun, stHalt} stateT;

	stateT state;
	opcodeT op;
	aluOpT aluSel;
	logic isArith; // two-operand ALU instruction
	logic isLong; // needs steps beyond T2
	logic lastStep;
	logic anyStrobe;

	assign op = opcodeT'(ir[31:27]);
	assign isArith = op inside {opAdd, opSub, opAnd, opOr, opShl, opShr};
	assign isLong = isArith || (op inside {opNot, opLdi, opIn, opOut});
	assign running = (state == stRun);
	assign halted = (state == stHalt);
	assign stepClear = running && lastStep;
	assign stepAdvance = running && !lastStep;

	always_comb begin
		case (op)
			opSub: aluSel = aluSub;
			opAnd: aluSel = aluAnd;
			opOr: aluSel = aluOr;
			opShl: aluSel = aluShl;
			opShr: aluSel = aluShr;
			opNot: aluSel = aluNot;
			default: aluSel = aluAdd;
		endcase
	end

	// one set of strobes per step
	always_comb begin
		ctl.busSrc = srcNone;
		ctl.regSel = selRa;
		ctl.regIn = 1'b0;
		ctl.marIn = 1'b0;
		ctl.mdrIn = 1'b0;
		ctl.irIn = 1'b0;
		ctl.yIn = 1'b0;
		ctl.zIn = 1'b0;
		ctl.incPc = 1'b0;
		ctl.read = 1'b0;
		ctl.outIn = 1'b0;
		ctl.aluOp = aluSel;
		ctl.pcClear = start && !running; // restart from idle or halt
		lastStep = 1'b0;
		if (running) begin
			case (step)
				3'd0: begin
					ctl.busSrc = srcPc;
					ctl.marIn = 1'b1;
					ctl.incPc = 1'b1;
				end
				3'd1: begin
					ctl.read = 1'b1;
					ctl.mdrIn = 1'b1;
				end
				3'd2: begin
					ctl.busSrc = srcMdr;
					ctl.irIn = 1'b1;
					lastStep = !isLong; // halt and no-op stop here
				end
				3'd3: begin
					if (isArith || op == opNot) begin
						ctl.busSrc = srcReg;
						ctl.regSel = selRb;
						ctl.yIn = isArith;
						ctl.zIn = (op == opNot);
					end else begin
						ctl.busSrc = (op == opLdi) ? srcImm : (op == opIn) ? srcInPort : srcReg;
						ctl.regIn = (op != opOut);
						ctl.outIn = (op == opOut);
						lastStep = 1'b1;
					end
				end
				3'd4: begin
					if (isArith) begin
						ctl.busSrc = srcReg;
						ctl.regSel = selRc;
						ctl.zIn = 1'b1;
					end else begin
						ctl.busSrc = srcZ; // not writes back here
						ctl.regIn = 1'b1;
						lastStep = 1'b1;
					end
				end
				default: begin
					ctl.busSrc = srcZ;
					ctl.regIn = 1'b1;
					lastStep = 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			state <= stIdle;
		end else if (running) begin
			if (step == 3'd2 && op == opHalt) state <= stHalt;
		end else if (start) begin
			state <= stRun;
		end
	end

	assign anyStrobe = ctl.regIn || ctl.marIn || ctl.mdrIn || ctl.irIn || ctl.yIn
		|| ctl.zIn || ctl.incPc || ctl.read || ctl.outIn;

	// idle and halted wait at T0 and leave the datapath untouched
	assert property (@(posedge Clock) disable iff (!rstN)
		!running |-> step == 3'd0 && !anyStrobe && ctl.busSrc == srcNone);

	// the step counter follows exactly one command per running cycle
	assert property (@(posedge Clock) disable iff (!rstN)
		running |=> step == ($past(stepClear) ? 3'd0 : $past(step) + 3'd1));

endmodule

`default_nettype wire

// ==== hdl/registerFile.sv ====
// general register file

`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module registerFile (
	input logic Clock,
	input logic rstN,
	ctrlIf.dp dp,
	input logic [`WORD_W-1:0] ir,
	input logic [`WORD_W-1:0] busIn,
	output logic [`WORD_W-1:0] readData
);
	import cpuPkg::*;

	localparam int IDX_W = $clog2(`NUM_REGS);

	logic [`WORD_W-1:0] regs [`NUM_REGS];
	logic [IDX_W-1:0] idx;

	// register number from the IR field the control unit names
	always_comb begin
		case (dp.regSel)
			selRb: idx = ir[22:19];
			selRc: idx = ir[18:15];
			default: idx = ir[26:23];
		endcase
	end

	assign readData = regs[idx];

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (dp.regIn) begin
			regs[idx] <= busIn; // write from bus at end of step
		end
	end

endmodule

`default_nettype wire

// ==== hdl/aluUnit.sv ====
// ALU with Y and Z registers

`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module aluUnit (
	input logic Clock,
	input logic rstN,
	ctrlIf.dp dp,
	input logic [`WORD_W-1:0] busIn,
	output logic [`WORD_W-1:0] zOut
);
	import cpuPkg::*;

	logic [`WORD_W-1:0] y; // first operand, held from the previous step
	logic [`WORD_W-1:0] z;
	logic [`WORD_W-1:0] result;
	logic [4:0] shamt;

	assign shamt = busIn[4:0]; // low five bits of Rc

	always_comb begin
		case (dp.aluOp)
			aluAdd: result = y + busIn; // wraps mod 2^32
			aluSub: result = y - busIn;
			aluAnd: result = y & busIn;
			aluOr: result = y | busIn;
			aluShl: result = y << shamt;
			aluShr: result = y >> shamt; // logical, zero fill
			aluNot: result = ~busIn;
			default: result = '0;
		endcase
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			y <= '0;
		end else if (dp.yIn) begin
			y <= busIn;
		end
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			z <= '0;
		end else if (dp.zIn) begin
			z <= result;
		end
	end

	assign zOut = z;

endmodule

`default_nettype wire

// ==== hdl/busRegs.sv ====
// bus registers and bus multiplexer

`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module busRegs (
	input logic Clock,
	input logic rstN,
	ctrlIf.dp dp,
	input logic [`WORD_W-1:0] regData,
	input logic [`WORD_W-1:0] zData,
	input logic [`WORD_W-1:0] memData,
	input logic [`WORD_W-1:0] inPort,
	output logic [`WORD_W-1:0] bus,
	output logic [`WORD_W-1:0] ir,
	output logic [`ADDR_W-1:0] memAddr,
	output logic [`WORD_W-1:0] outPort,
	output logic outValid
);
	import cpuPkg::*;

	localparam int IMM_W = 19;

	logic [`ADDR_W-1:0] pc;
	logic [`ADDR_W-1:0] mar;
	logic [`WORD_W-1:0] mdr;
	logic [`WORD_W-1:0] irReg;
	logic [`WORD_W-1:0] imm;
	logic irPending; // MDR holds a fetched word not yet in IR

	assign imm = {{(`WORD_W - IMM_W){irReg[IMM_W-1]}}, irReg[IMM_W-1:0]};

	// decode sees the new instruction already in T2
	assign ir = irPending ? mdr : irReg;
	assign memAddr = mar;

	always_comb begin
		case (dp.busSrc)
			srcPc: bus = {{(`WORD_W - `ADDR_W){1'b0}}, pc};
			srcMdr: bus = mdr;
			srcReg: bus = regData;
			srcZ: bus = zData;
			srcImm: bus = imm;
			srcInPort: bus = inPort;
			default: bus = '0;
		endcase
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			irReg <= '0;
			irPending <= 1'b0;
			outPort <= '0;
			outValid <= 1'b0;
		end else begin
			if (dp.pcClear) pc <= '0;
			else if (dp.incPc) pc <= pc + 1'b1;
			if (dp.irIn) irReg <= bus;
			if (dp.mdrIn) irPending <= 1'b1;
			else if (dp.irIn) irPending <= 1'b0;
			if (dp.outIn) outPort <= bus;
			outValid <= dp.outIn; // high while the new value is first shown
		end
	end

	always_ff @(posedge Clock) begin
		if (dp.marIn) mar <= bus[`ADDR_W-1:0];
		if (dp.mdrIn) mdr <= dp.read ? memData : bus;
	end

	// bus loads need a real driver unless the MDR reads memory
	assert property (@(posedge Clock) disable iff (!rstN)
		(dp.marIn || dp.irIn || dp.yIn || dp.zIn || dp.regIn || dp.outIn
			|| (dp.mdrIn && !dp.read))
		|-> dp.busSrc inside {srcPc, srcMdr, srcReg, srcZ, srcImm, srcInPort});

endmodule

`default_nettype wire

// ==== hdl/cpuTop.sv ====
// single-bus processor top

`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module cpuTop (
	input logic Clock,
	input logic rstN,
	input logic start, // one-cycle pulse, run from address 0
	input logic [`WORD_W-1:0] memData,
	input logic [`WORD_W-1:0] inPort,
	output logic [`ADDR_W-1:0] memAddr,
	output logic memRead,
	output logic outValid,
	output logic running,
	output logic halted,
	output logic [`WORD_W-1:0] outPort
);

	logic [`WORD_W-1:0] ir;
	logic [`WORD_W-1:0] bus;
	logic [`WORD_W-1:0] regData;
	logic [`WORD_W-1:0] zData;
	logic [2:0] step;
	logic stepAdvance;
	logic stepClear;

	ctrlIf ctrl ();

	assign memRead = ctrl.read;

	stepCounter stepCounter_inst (
		.Clock(Clock),
		.rstN(rstN),
		.advance(stepAdvance),
		.clear(stepClear),
		.step(step)
	);

	controlFsm controlFsm_inst (
		.Clock(Clock),
		.rstN(rstN),
		.start(start),
		.ir(ir),
		.step(step),
		.stepAdvance(stepAdvance),
		.stepClear(stepClear),
		.running(running),
		.halted(halted),
		.ctl(ctrl.ctl)
	);

	registerFile registerFile_inst (
		.Clock(Clock),
		.rstN(rstN),
		.dp(ctrl.dp),
		.ir(ir),
		.busIn(bus),
		.readData(regData)
	);

	aluUnit aluUnit_inst (
		.Clock(Clock),
		.rstN(rstN),
		.dp(ctrl.dp),
		.busIn(bus),
		.zOut(zData)
	);

	busRegs busRegs_inst (
		.Clock(Clock),
		.rstN(rstN),
		.dp(ctrl.dp),
		.regData(regData),
		.zData(zData),
		.memData(memData),
		.inPort(inPort),
		.bus(bus),
		.ir(ir),
		.memAddr(memAddr),
		.outPort(outPort),
		.outValid(outValid)
	);

endmodule

`default_nettype wire

// ==== verif/clockGen.sv ====
// testbench clock and reset

`timescale 1ns/10ps
`default_nettype none

module clockGen #(
	parameter int RESET_CYCLES = 16
) (
	output logic Clock,
	output logic rstN
);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock; // 10 ns period
	end

	initial begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge Clock);
		rstN <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== verif/cpuTb.sv ====
// processor directed tests

`timescale 1ns/10ps
`default_nettype none
`include "cpu_cfg.svh"

module cpuTb;
	import cpuPkg::*;

	logic Clock;
	logic rstN;
	logic start;
	logic [`WORD_W-1:0] memData;
	logic [`WORD_W-1:0] inPort;
	logic [`ADDR_W-1:0] memAddr;
	logic memRead;
	logic outValid;
	logic running;
	logic halted;
	logic [`WORD_W-1:0] outPort;

	logic [`WORD_W-1:0] mem [1 << `ADDR_W];
	logic [`WORD_W-1:0] model [`NUM_REGS]; // expected register contents
	logic [`WORD_W-1:0] expQ [$];
	logic [`WORD_W-1:0] gotQ [$];
	int progLen;
	int fetches; // instruction fetches seen in this run
	int errors;
	int testsRun;
	int testsFailed;

	clockGen clockGen_inst (.Clock(Clock), .rstN(rstN));

	cpuTop cpuTop_inst (
		.Clock(Clock),
		.rstN(rstN),
		.start(start),
		.memData(memData),
		.inPort(inPort),
		.memAddr(memAddr),
		.memRead(memRead),
		.outValid(outValid),
		.running(running),
		.halted(halted),
		.outPort(outPort)
	);

	assign memData = mem[memAddr]; // asynchronous instruction memory

	// one value per outValid pulse and one read per fetch
	always @(negedge Clock) begin
		if (rstN && outValid) begin
			gotQ.push_back(outPort);
		end
		if (rstN && memRead) begin
			checkEq("memAddr", 32'(memAddr), 32'(fetches)); // straight-line programs
			fetches++;
		end
	end

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	function automatic logic [31:0] signExt(input logic [18:0] imm);
		return {{13{imm[18]}}, imm};
	endfunction

	task automatic newProgram();
		for (int a = 0; a < (1 << `ADDR_W); a++) begin
			mem[a] = {opHalt, 18'h0, 9'(a)}; // stray fetches halt
		end
		progLen = 0;
		expQ.delete();
	endtask

	task automatic emit(input logic [31:0] word);
		mem[progLen] = word;
		progLen++;
	endtask

	task automatic addLdi(input int ra, input logic [18:0] imm);
		emit({opLdi, 4'(ra), 4'h0, imm});
		model[ra] = signExt(imm);
	endtask

	task automatic addAlu(input opcodeT op, input int ra, input int rb, input int rc);
		logic [31:0] a;
		logic [31:0] b;
		a = model[rb];
		b = model[rc];
		emit({op, 4'(ra), 4'(rb), 4'(rc), 15'h0});
		case (op)
			opAdd: model[ra] = a + b;
			opSub: model[ra] = a - b;
			opAnd: model[ra] = a & b;
			opOr: model[ra] = a | b;
			opShl: model[ra] = a << b[4:0];
			opShr: model[ra] = a >> b[4:0];
			default: model[ra] = ~a; // not takes Rb only
		endcase
	endtask

	task automatic addIn(input int ra, input logic [31:0] portVal);
		emit({opIn, 4'(ra), 23'h0});
		model[ra] = portVal;
	endtask

	task automatic addOut(input int ra);
		emit({opOut, 4'(ra), 23'h0});
		expQ.push_back(model[ra]);
	endtask

	task automatic runProgram();
		int n;
		gotQ.delete();
		fetches = 0;
		@(posedge Clock);
		start <= 1'b1;
		@(posedge Clock);
		start <= 1'b0;
		@(negedge Clock);
		checkEq("halted", 32'(halted), 32'h0);
		checkEq("running", 32'(running), 32'h1);
		n = 0;
		while (!halted && n < 2000) begin
			@(negedge Clock);
			n++;
		end
		if (!halted) begin
			$display("timeout: halted did not rise within 2000 cycles");
			$display("tests failed");
			$finish;
		end
	endtask

	task automatic compareOutputs();
		checkEq("memRead pulses", 32'(fetches), 32'(progLen));
		checkEq("outValid pulses", 32'(gotQ.size()), 32'(expQ.size()));
		for (int i = 0; i < expQ.size() && i < gotQ.size(); i++) begin
			checkEq($sformatf("outPort[%0d]", i), gotQ[i], expQ[i]);
		end
	endtask

	task automatic finishTest(input string name, input int errBefore);
		testsRun++;
		if (errors != errBefore) testsFailed++;
		$display("%s: %s", name, (errors == errBefore) ? "pass" : "FAIL");
	endtask

	task automatic idleAfterReset();
		int e0;
		e0 = errors;
		repeat (20) begin
			@(negedge Clock);
			checkEq("running", 32'(running), 32'h0);
			checkEq("halted", 32'(halted), 32'h0);
			checkEq("outValid", 32'(outValid), 32'h0);
			checkEq("memRead", 32'(memRead), 32'h0);
			checkEq("outPort", outPort, 32'h0);
		end
		finishTest("idle after reset", e0);
	endtask

	task automatic loadImmediateOut();
		int e0;
		e0 = errors;
		newProgram();
		addLdi(1, 19'h00012);
		addLdi(2, 19'h7FFFF); // -1
		addLdi(3, 19'h40000); // most negative immediate
		addLdi(4, 19'($urandom));
		for (int r = 1; r <= 4; r++) begin
			addOut(r);
		end
		emit({opHalt, 27'h0});
		runProgram();
		compareOutputs();
		finishTest("load immediate and output", e0);
	endtask

	task automatic arithLogic();
		int e0;
		e0 = errors;
		newProgram();
		addLdi(1, 19'($urandom));
		addLdi(2, 19'($urandom));
		addLdi(8, 19'h7FFFF);
		addAlu(opAdd, 3, 1, 2);
		addAlu(opSub, 4, 1, 2);
		addAlu(opAnd, 5, 1, 2);
		addAlu(opOr, 6, 1, 2);
		addAlu(opAdd, 9, 8, 8); // carries out of bit 31
		addAlu(opSub, 10, 2, 1);
		addOut(3);
		addOut(4);
		addOut(5);
		addOut(6);
		addOut(9);
		addOut(10);
		emit({opHalt, 27'h0});
		runProgram();
		compareOutputs();
		finishTest("add sub and or", e0);
	endtask

	task automatic shiftAndNot();
		int e0;
		e0 = errors;
		newProgram();
		addLdi(1, 19'($urandom));
		addLdi(2, 19'($urandom)); // only bits 4..0 matter
		addLdi(7, 19'h40001); // negative, zero fill checked on right shift
		addLdi(8, 19'h7FFE4); // shift by 4 with the upper bits set
		addAlu(opShl, 3, 1, 2);
		addAlu(opShr, 4, 1, 2);
		addAlu(opShr, 5, 7, 8);
		addAlu(opNot, 6, 1, 0);
		for (int r = 3; r <= 6; r++) begin
			addOut(r);
		end
		emit({opHalt, 27'h0});
		runProgram();
		compareOutputs();
		finishTest("shifts and not", e0);
	endtask

	task automatic inputAndNop();
		int e0;
		logic [31:0] portVal;
		e0 = errors;
		portVal = $urandom;
		@(posedge Clock);
		inPort <= portVal;
		newProgram();
		addLdi(2, 19'($urandom));
		addIn(5, portVal);
		emit({5'h10, 27'($urandom)}); // unused opcode
		addOut(5);
		addOut(2);
		emit({opHalt, 27'h0});
		runProgram();
		compareOutputs();
		finishTest("input and no-op", e0);
	endtask

	task automatic restartAfterHalt();
		int e0;
		e0 = errors;
		newProgram();
		addLdi(1, 19'($urandom));
		addLdi(2, 19'($urandom));
		addAlu(opAdd, 3, 1, 2);
		addOut(3);
		addOut(1);
		emit({opHalt, 27'h0});
		runProgram();
		compareOutputs();
		runProgram(); // same program, same outputs
		compareOutputs();
		finishTest("restart after halt", e0);
	endtask

	initial begin
		int n;
		start = 1'b0;
		inPort = '0;
		fetches = 0;
		errors = 0;
		testsRun = 0;
		testsFailed = 0;
		void'($urandom(32'h245f72ec));
		n = 0;
		while (!rstN && n < 100) begin
			@(negedge Clock);
			n++;
		end
		if (!rstN) begin
			$display("reset was never released");
			$display("tests failed");
			$finish;
		end else begin
			idleAfterReset();
			loadImmediateOut();
			arithLogic();
			shiftAndNot();
			inputAndNop();
			restartAfterHalt();
			$display("%0d tests run, %0d failed, %0d mismatches", testsRun, testsFailed, errors);
			if (errors == 0) begin
				$display("all tests passed");
			end else begin
				$display("tests failed");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/cpuPkg.sv
hdl/ctrlIf.sv
hdl/stepCounter.sv
hdl/controlFsm.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/busRegs.sv
hdl/cpuTop.sv
verif/clockGen.sv
verif/cpuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cpuTb
BUILD_DIR ?= build

SOURCES := $(shell grep -v '^+' project.f) hdl/cpu_cfg.svh
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): project.f $(SOURCES)
	$(VERILATOR) --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf $(BUILD_DIR)
